/* Makefile */
SIM = obj_dir/Vexe_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module exe_stage_tb -f files.f

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* design/alu.sv */
module alu (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  cpu_isa_pkg::alu_op_t         op,
  input  logic [cpu_isa_pkg::xlen-1:0] src1,
  input  logic [cpu_isa_pkg::xlen-1:0] src2,
  output logic                         done,
  output logic [cpu_isa_pkg::xlen-1:0] result
);

  localparam int w = cpu_isa_pkg::xlen;

  logic         is_mul;
  logic         is_div;
  logic         sub_like;
  logic [w-1:0] adder_b;
  logic [w:0]   adder_out;
  logic         slt_res;
  logic         sltu_res;
  logic [w-1:0] simple_result;
  logic [33:0]  mul_x;
  logic [33:0]  mul_y;
  logic [67:0]  mul_z;
  logic         mul_valid;
  logic         div_signed;
  logic [w-1:0] quotient;
  logic [w-1:0] remainder;
  logic         div_done;
  logic         sub_done;
  logic [w-1:0] sub_result;
  logic         held;
  logic [w-1:0] held_result;

  assign is_mul = op[cpu_isa_pkg::op_mul] | op[cpu_isa_pkg::op_mulh] | op[cpu_isa_pkg::op_mulhu];
  assign is_div = op[cpu_isa_pkg::op_div] | op[cpu_isa_pkg::op_mod]
                | op[cpu_isa_pkg::op_divu] | op[cpu_isa_pkg::op_modu];

  // shared adder for add/sub/compares
  assign sub_like  = op[cpu_isa_pkg::op_sub] | op[cpu_isa_pkg::op_slt] | op[cpu_isa_pkg::op_sltu];
  assign adder_b   = sub_like ? ~src2 : src2;
  assign adder_out = {1'b0, src1} + {1'b0, adder_b} + {{w{1'b0}}, sub_like};
  assign slt_res   = (src1[w-1] & ~src2[w-1]) | (~(src1[w-1] ^ src2[w-1]) & adder_out[w-1]);
  assign sltu_res  = ~adder_out[w];

  always_comb begin
    simple_result = '0;
    case (1'b1)
      op[cpu_isa_pkg::op_add], op[cpu_isa_pkg::op_sub]: simple_result = adder_out[w-1:0];
      op[cpu_isa_pkg::op_slt]:  simple_result = {{(w-1){1'b0}}, slt_res};
      op[cpu_isa_pkg::op_sltu]: simple_result = {{(w-1){1'b0}}, sltu_res};
      op[cpu_isa_pkg::op_and]:  simple_result = src1 & src2;
      op[cpu_isa_pkg::op_or]:   simple_result = src1 | src2;
      op[cpu_isa_pkg::op_nor]:  simple_result = ~(src1 | src2);
      op[cpu_isa_pkg::op_xor]:  simple_result = src1 ^ src2;
      op[cpu_isa_pkg::op_sll]:  simple_result = src1 << src2[4:0];
      op[cpu_isa_pkg::op_srl]:  simple_result = src1 >> src2[4:0];
      op[cpu_isa_pkg::op_sra]:  simple_result = $signed(src1) >>> src2[4:0];
      op[cpu_isa_pkg::op_lui]:  simple_result = src2;  // imm already placed by decode
      default: simple_result = '0;
    endcase
  end

  // zero-extend only for mulhu
  assign mul_x = {{2{src1[w-1] & ~op[cpu_isa_pkg::op_mulhu]}}, src1};
  assign mul_y = {{2{src2[w-1] & ~op[cpu_isa_pkg::op_mulhu]}}, src2};

  booth_multiplier u_mul (
    .clk       (clk),
    .x         (mul_x),
    .y         (mul_y),
    .in_valid  (start & is_mul),
    .z         (mul_z),
    .out_valid (mul_valid)
  );

  assign div_signed = op[cpu_isa_pkg::op_div] | op[cpu_isa_pkg::op_mod];

  iterative_divider u_div (
    .clk       (clk),
    .reset     (reset),
    .start     (start & is_div),
    .is_signed (div_signed),
    .dividend  (src1),
    .divisor   (src2),
    .quotient  (quotient),
    .remainder (remainder),
    .done      (div_done)
  );

  assign sub_done = (is_mul & mul_valid) | (is_div & div_done);

  always_comb begin
    if (is_mul) sub_result = op[cpu_isa_pkg::op_mul] ? mul_z[31:0] : mul_z[63:32];
    else if (op[cpu_isa_pkg::op_div] || op[cpu_isa_pkg::op_divu]) sub_result = quotient;
    else sub_result = remainder;
  end

  // sub-unit done is a pulse, keep it until the next start
  always_ff @(posedge clk) begin
    if (reset) held <= 1'b0;
    else if (start) held <= 1'b0;
    else if (sub_done) held <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (sub_done) held_result <= sub_result;
  end

  assign done   = ~(is_mul | is_div) | (~start & (sub_done | held));
  assign result = ~(is_mul | is_div) ? simple_result : (held ? held_result : sub_result);

endmodule

/* design/booth_multiplier.sv */
module booth_multiplier (
  input  logic        clk,
  input  logic [33:0] x,
  input  logic [33:0] y,
  input  logic        in_valid,
  output logic [67:0] z,
  output logic        out_valid
);

  localparam int n_pp = 17;

  logic [67:0] x_ext;
  logic [34:0] y_pad;  // y with implicit zero below bit 0
  logic [67:0] pp [n_pp];
  logic [67:0] sum;

  assign x_ext = {{34{x[33]}}, x};
  assign y_pad = {y, 1'b0};

  // radix-4 recoding, one group per two multiplier bits
  for (genvar i = 0; i < n_pp; i++) begin : g_pp
    logic [2:0]  grp;
    logic [67:0] sel;

    assign grp = y_pad[2*i +: 3];

    always_comb begin
      case (grp)
        3'b001, 3'b010: sel = x_ext;
        3'b011:         sel = x_ext << 1;
        3'b100:         sel = -(x_ext << 1);
        3'b101, 3'b110: sel = -x_ext;
        default:        sel = '0;
      endcase
    end

    assign pp[i] = sel << (2 * i);
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < n_pp; k++) begin
      sum = sum + pp[k];
    end
  end

  always_ff @(posedge clk) begin
    z         <= sum;
    out_valid <= in_valid;
  end

endmodule

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

  localparam int xlen       = 32;
  localparam int alu_op_w   = 19;
  localparam int div_cycles = 33;  // operand load plus 32 quotient steps

  // one-hot alu op bit positions
  localparam int op_add   = 0;
  localparam int op_sub   = 1;
  localparam int op_slt   = 2;
  localparam int op_sltu  = 3;
  localparam int op_and   = 4;
  localparam int op_or    = 5;
  localparam int op_nor   = 6;
  localparam int op_xor   = 7;
  localparam int op_sll   = 8;
  localparam int op_srl   = 9;
  localparam int op_sra   = 10;
  localparam int op_lui   = 11;
  localparam int op_mul   = 12;
  localparam int op_mulh  = 13;
  localparam int op_mulhu = 14;
  localparam int op_div   = 15;
  localparam int op_mod   = 16;
  localparam int op_divu  = 17;
  localparam int op_modu  = 18;

  // store kind bits
  localparam int st_b = 0;
  localparam int st_h = 1;
  localparam int st_w = 2;

  typedef logic [alu_op_w-1:0] alu_op_t;
  typedef logic [4:0]          load_op_t;   // b, h, w, bu, hu
  typedef logic [2:0]          store_op_t;  // b, h, w
  typedef logic [4:0]          reg_idx_t;

endpackage

/* design/exe_bus_pkg.sv */
package exe_bus_pkg;

  // decode -> execute
  typedef struct packed {
    logic [cpu_isa_pkg::xlen-1:0] pc;
    logic [cpu_isa_pkg::xlen-1:0] src1;
    logic [cpu_isa_pkg::xlen-1:0] src2;
    cpu_isa_pkg::alu_op_t         alu_op;
    cpu_isa_pkg::load_op_t        load_op;
    cpu_isa_pkg::store_op_t       store_op;
    logic [cpu_isa_pkg::xlen-1:0] rkd_value;  // store data
    logic                         gr_we;
    cpu_isa_pkg::reg_idx_t        dest;
  } ds2es_bus_t;

  // held copy inside execute
  typedef ds2es_bus_t es_inst_t;

  // execute -> memory
  typedef struct packed {
    logic [cpu_isa_pkg::xlen-1:0] pc;
    logic [cpu_isa_pkg::xlen-1:0] alu_result;
    cpu_isa_pkg::load_op_t        load_op;
    cpu_isa_pkg::reg_idx_t        dest;
    logic                         gr_we;
  } es2ms_bus_t;

  // data sram request
  typedef struct packed {
    logic                         en;
    logic [3:0]                   we;
    logic [cpu_isa_pkg::xlen-1:0] addr;
    logic [cpu_isa_pkg::xlen-1:0] wdata;
  } sram_req_t;

endpackage

/* design/exe_stage.sv */
module exe_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ds2es_valid,
  input  exe_bus_pkg::ds2es_bus_t ds2es_bus,
  output logic                    es_allowin,
  output logic                    es2ms_valid,
  output exe_bus_pkg::es2ms_bus_t es2ms_bus,
  input  logic                    ms_allowin,
  output exe_bus_pkg::sram_req_t  data_sram
);

  exe_bus_pkg::es_inst_t        es_inst;
  exe_bus_pkg::es2ms_bus_t      es_result;
  logic                         es_ready;    // issue latch holds a finished op
  logic                         es_first;
  logic                         alu_done;
  logic [cpu_isa_pkg::xlen-1:0] alu_result;
  logic                         res_allowin;
  logic                         issue;

  pipe_reg #(
    .payload_t (exe_bus_pkg::es_inst_t)
  ) u_issue (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (ds2es_valid),
    .in_data     (ds2es_bus),
    .allowin     (es_allowin),
    .ready_go    (alu_done),
    .out_valid   (es_ready),
    .out_data    (es_inst),
    .out_allowin (res_allowin),
    .first_cycle (es_first)
  );

  alu u_alu (
    .clk    (clk),
    .reset  (reset),
    .start  (es_first),
    .op     (es_inst.alu_op),
    .src1   (es_inst.src1),
    .src2   (es_inst.src2),
    .done   (alu_done),
    .result (alu_result)
  );

  assign issue = es_ready & res_allowin;  // handoff edge, request goes out once

  store_unit u_store (
    .issue     (issue),
    .store_op  (es_inst.store_op),
    .load_op   (es_inst.load_op),
    .addr      (alu_result),
    .rkd_value (es_inst.rkd_value),
    .req       (data_sram)
  );

  assign es_result = '{
    pc:         es_inst.pc,
    alu_result: alu_result,
    load_op:    es_inst.load_op,
    dest:       es_inst.dest,
    gr_we:      es_inst.gr_we
  };

  pipe_reg #(
    .payload_t (exe_bus_pkg::es2ms_bus_t)
  ) u_result (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (es_ready),
    .in_data     (es_result),
    .allowin     (res_allowin),
    .ready_go    (1'b1),
    .out_valid   (es2ms_valid),
    .out_data    (es2ms_bus),
    .out_allowin (ms_allowin),
    .first_cycle ()
  );

endmodule

/* design/iterative_divider.sv */
module iterative_divider (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         is_signed,
  input  logic [cpu_isa_pkg::xlen-1:0] dividend,
  input  logic [cpu_isa_pkg::xlen-1:0] divisor,
  output logic [cpu_isa_pkg::xlen-1:0] quotient,
  output logic [cpu_isa_pkg::xlen-1:0] remainder,
  output logic                         done
);

  localparam int w = cpu_isa_pkg::xlen;

  logic         busy;
  logic [5:0]   cnt;
  logic [w-1:0] rem;
  logic [w-1:0] quo;      // dividend bits shift out, quotient bits shift in
  logic [w-1:0] dsr;
  logic [w-1:0] dvd;
  logic         q_neg;
  logic         r_neg;
  logic         div_zero;
  logic [w-1:0] abs_dvd;
  logic [w-1:0] abs_dsr;
  logic [w:0]   shifted;
  logic [w+1:0] diff;

  assign abs_dvd = (is_signed && dividend[w-1]) ? -dividend : dividend;
  assign abs_dsr = (is_signed && divisor[w-1]) ? -divisor : divisor;

  assign shifted = {rem, quo[w-1]};
  assign diff    = {1'b0, shifted} - {2'b00, dsr};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      cnt  <= 6'(cpu_isa_pkg::div_cycles - 1);
    end else if (busy) begin
      cnt <= cnt - 6'd1;
      if (cnt == 6'd1) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem      <= '0;
      quo      <= abs_dvd;
      dsr      <= abs_dsr;
      dvd      <= dividend;
      q_neg    <= is_signed & (dividend[w-1] ^ divisor[w-1]);
      r_neg    <= is_signed & dividend[w-1];
      div_zero <= (divisor == '0);
    end else if (busy) begin
      if (!diff[w+1]) begin  // trial subtract fits
        rem <= diff[w-1:0];
        quo <= {quo[w-2:0], 1'b1};
      end else begin
        rem <= shifted[w-1:0];
        quo <= {quo[w-2:0], 1'b0};
      end
    end
  end

  // min / -1 comes out as min with zero remainder without special casing
  assign quotient  = div_zero ? '1 : (q_neg ? -quo : quo);
  assign remainder = div_zero ? dvd : (r_neg ? -rem : rem);

endmodule

/* design/pipe_reg.sv */
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     allowin,
  input  logic     ready_go,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_allowin,
  output logic     first_cycle
);

  logic valid;
  logic load;

  assign allowin   = !valid || (ready_go && out_allowin);
  assign load      = in_valid && allowin;
  assign out_valid = valid && ready_go;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= 1'b0;
      first_cycle <= 1'b0;
    end else begin
      if (allowin) valid <= in_valid;
      first_cycle <= load;  // one cycle after each load
    end
  end

  always_ff @(posedge clk) begin
    if (load) out_data <= in_data;
  end

endmodule

/* design/store_unit.sv */
module store_unit (
  input  logic                         issue,
  input  cpu_isa_pkg::store_op_t       store_op,
  input  cpu_isa_pkg::load_op_t        load_op,
  input  logic [cpu_isa_pkg::xlen-1:0] addr,
  input  logic [cpu_isa_pkg::xlen-1:0] rkd_value,
  output exe_bus_pkg::sram_req_t       req
);

  logic        is_store;
  logic [3:0]  byte_sel;
  logic [3:0]  half_sel;
  logic [3:0]  strb;
  logic [31:0] st_data;

  assign is_store = |store_op;
  assign byte_sel = 4'b0001 << addr[1:0];
  assign half_sel = addr[1] ? 4'b1100 : 4'b0011;

  assign strb = ({4{store_op[cpu_isa_pkg::st_b]}} & byte_sel)
              | ({4{store_op[cpu_isa_pkg::st_h]}} & half_sel)
              | ({4{store_op[cpu_isa_pkg::st_w]}} & 4'b1111);

  // replicate so every lane sees the data
  always_comb begin
    st_data = rkd_value;
    if (store_op[cpu_isa_pkg::st_b]) st_data = {4{rkd_value[7:0]}};
    else if (store_op[cpu_isa_pkg::st_h]) st_data = {2{rkd_value[15:0]}};
  end

  assign req.en    = issue & (is_store | (|load_op));
  assign req.we    = {4{req.en}} & strb;  // zero for loads
  assign req.addr  = addr;
  assign req.wdata = st_data;

endmodule

/* files.f */
+incdir+include
design/cpu_isa_pkg.sv
design/exe_bus_pkg.sv
design/pipe_reg.sv
design/booth_multiplier.sv
design/iterative_divider.sv
design/alu.sv
design/store_unit.sv
design/exe_stage.sv
verification/exe_stage_tb.sv

/* include/exe_tb_vectors.svh */
// columns: op, src1, src2, store kind, load kind, rkd, dest, random, expected result
// store kind b/h/w = 001/010/100, load w = 00100; random rows take the model result
localparam int n_vec = 33;

localparam vec_t vectors [n_vec] = '{
  '{cpu_isa_pkg::op_add,   32'h5,         32'h7,         3'b000, 5'b0, 32'h0, 5'd1, 1'b0, 32'hc},
  '{cpu_isa_pkg::op_sub,   32'h5,         32'h7,         3'b000, 5'b0, 32'h0, 5'd2, 1'b0, 32'hfffffffe},
  '{cpu_isa_pkg::op_slt,   32'hffffffff,  32'h1,         3'b000, 5'b0, 32'h0, 5'd3, 1'b0, 32'h1},
  '{cpu_isa_pkg::op_sltu,  32'hffffffff,  32'h1,         3'b000, 5'b0, 32'h0, 5'd4, 1'b0, 32'h0},
  '{cpu_isa_pkg::op_and,   32'hf0f0f0f0,  32'hff00ff00,  3'b000, 5'b0, 32'h0, 5'd5, 1'b0, 32'hf000f000},
  '{cpu_isa_pkg::op_or,    32'hf0f0f0f0,  32'hff00ff00,  3'b000, 5'b0, 32'h0, 5'd6, 1'b0, 32'hfff0fff0},
  '{cpu_isa_pkg::op_nor,   32'hf0f0f0f0,  32'hff00ff00,  3'b000, 5'b0, 32'h0, 5'd7, 1'b0, 32'h000f000f},
  '{cpu_isa_pkg::op_xor,   32'hf0f0f0f0,  32'hff00ff00,  3'b000, 5'b0, 32'h0, 5'd8, 1'b0, 32'h0ff00ff0},
  '{cpu_isa_pkg::op_sll,   32'h1,         32'h23,        3'b000, 5'b0, 32'h0, 5'd9, 1'b0, 32'h8},
  '{cpu_isa_pkg::op_srl,   32'h80000000,  32'h4,         3'b000, 5'b0, 32'h0, 5'd10, 1'b0, 32'h08000000},
  '{cpu_isa_pkg::op_sra,   32'h80000000,  32'h4,         3'b000, 5'b0, 32'h0, 5'd11, 1'b0, 32'hf8000000},
  '{cpu_isa_pkg::op_lui,   32'h0,         32'h12345000,  3'b000, 5'b0, 32'h0, 5'd12, 1'b0, 32'h12345000},
  '{cpu_isa_pkg::op_mul,   32'hfffffffe,  32'h3,         3'b000, 5'b0, 32'h0, 5'd13, 1'b0, 32'hfffffffa},
  '{cpu_isa_pkg::op_mulh,  32'hfffffffe,  32'h3,         3'b000, 5'b0, 32'h0, 5'd14, 1'b0, 32'hffffffff},
  '{cpu_isa_pkg::op_mulhu, 32'hfffffffe,  32'h3,         3'b000, 5'b0, 32'h0, 5'd15, 1'b0, 32'h2},
  '{cpu_isa_pkg::op_div,   32'hfffffff9,  32'h2,         3'b000, 5'b0, 32'h0, 5'd16, 1'b0, 32'hfffffffd},
  '{cpu_isa_pkg::op_mod,   32'hfffffff9,  32'h2,         3'b000, 5'b0, 32'h0, 5'd17, 1'b0, 32'hffffffff},
  '{cpu_isa_pkg::op_divu,  32'hfffffff9,  32'h2,         3'b000, 5'b0, 32'h0, 5'd18, 1'b0, 32'h7ffffffc},
  '{cpu_isa_pkg::op_modu,  32'hfffffff9,  32'h2,         3'b000, 5'b0, 32'h0, 5'd19, 1'b0, 32'h1},
  '{cpu_isa_pkg::op_div,   32'h80000000,  32'hffffffff,  3'b000, 5'b0, 32'h0, 5'd20, 1'b0, 32'h80000000},
  '{cpu_isa_pkg::op_mod,   32'h80000000,  32'hffffffff,  3'b000, 5'b0, 32'h0, 5'd21, 1'b0, 32'h0},
  '{cpu_isa_pkg::op_div,   32'h1234,      32'h0,         3'b000, 5'b0, 32'h0, 5'd22, 1'b0, 32'hffffffff},
  '{cpu_isa_pkg::op_modu,  32'h1234,      32'h0,         3'b000, 5'b0, 32'h0, 5'd23, 1'b0, 32'h1234},
  '{cpu_isa_pkg::op_add,   32'h1000,      32'h3,         3'b001, 5'b0, 32'ha5, 5'd0, 1'b0, 32'h1003},
  '{cpu_isa_pkg::op_add,   32'h2000,      32'h2,         3'b010, 5'b0, 32'hbeef, 5'd0, 1'b0, 32'h2002},
  '{cpu_isa_pkg::op_add,   32'h3000,      32'h0,         3'b100, 5'b0, 32'h12345678, 5'd0, 1'b0, 32'h3000},
  '{cpu_isa_pkg::op_add,   32'h4000,      32'h4,         3'b000, 5'b00100, 32'h0, 5'd24, 1'b0, 32'h4004},
  '{cpu_isa_pkg::op_add,   32'h5000,      32'h0,         3'b010, 5'b0, 32'h0000c3d2, 5'd0, 1'b0, 32'h5000},
  '{cpu_isa_pkg::op_sub,   32'h0,         32'h0,         3'b000, 5'b0, 32'h0, 5'd25, 1'b1, 32'h0},
  '{cpu_isa_pkg::op_mulhu, 32'h0,         32'h0,         3'b000, 5'b0, 32'h0, 5'd26, 1'b1, 32'h0},
  '{cpu_isa_pkg::op_div,   32'h0,         32'h0,         3'b000, 5'b0, 32'h0, 5'd27, 1'b1, 32'h0},
  '{cpu_isa_pkg::op_modu,  32'h0,         32'h0,         3'b000, 5'b0, 32'h0, 5'd28, 1'b1, 32'h0},
  '{cpu_isa_pkg::op_sra,   32'h0,         32'h0,         3'b000, 5'b0, 32'h0, 5'd29, 1'b1, 32'h0}
};

/* verification/exe_stage_tb.sv */
module exe_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    int          op;     // alu op bit position
    logic [31:0] src1;
    logic [31:0] src2;
    logic [2:0]  st;
    logic [4:0]  ld;
    logic [31:0] rkd;
    logic [4:0]  dest;
    logic        rnd;    // operands drawn at run time and checked against the model
    logic [31:0] exp;
  } vec_t;

  typedef struct {
    int          idx;
    int          pass_no;
    logic [31:0] pc;
    logic [31:0] result;
    logic [4:0]  ld;
    logic [4:0]  dest;
    logic        gr_we;
  } exp_t;

  typedef struct {
    exe_bus_pkg::sram_req_t req;
    bit                     is_store;
  } mem_item_t;

  `include "exe_tb_vectors.svh"

  localparam int reset_cycles  = 5;
  localparam int timeout_limit = 2 * n_vec * (cpu_isa_pkg::div_cycles + 10) + reset_cycles;

  logic                    clk;
  logic                    reset;
  logic                    ds2es_valid;
  exe_bus_pkg::ds2es_bus_t ds2es_bus;
  logic                    es_allowin;
  logic                    es2ms_valid;
  exe_bus_pkg::es2ms_bus_t es2ms_bus;
  logic                    ms_allowin;
  exe_bus_pkg::sram_req_t  data_sram;

  integer      seed;
  int          errors;
  int          checks;
  int          results_seen;
  int          cycles;
  int          seq;
  int          xfer_cyc [n_vec];
  exp_t        res_q [$];
  mem_item_t   mem_q [$];
  exp_t        cur_exp;
  mem_item_t   cur_mem;
  bit          cur_is_mem;

  exe_stage dut (
    .clk         (clk),
    .reset       (reset),
    .ds2es_valid (ds2es_valid),
    .ds2es_bus   (ds2es_bus),
    .es_allowin  (es_allowin),
    .es2ms_valid (es2ms_valid),
    .es2ms_bus   (es2ms_bus),
    .ms_allowin  (ms_allowin),
    .data_sram   (data_sram)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] model_alu(input int op, input logic [31:0] a, b);
    logic signed [63:0] sp;
    logic [63:0]        up;
    logic               ovf;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sp  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    up  = {32'b0, a} * {32'b0, b};
    sq  = a;  // min / -1 keeps the dividend
    sr  = '0;
    if (b != 0 && !ovf) begin
      sq = $signed(a) / $signed(b);
      sr = $signed(a) % $signed(b);
    end
    case (op)
      cpu_isa_pkg::op_add:   return a + b;
      cpu_isa_pkg::op_sub:   return a - b;
      cpu_isa_pkg::op_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_isa_pkg::op_sltu:  return (a < b) ? 32'd1 : 32'd0;
      cpu_isa_pkg::op_and:   return a & b;
      cpu_isa_pkg::op_or:    return a | b;
      cpu_isa_pkg::op_nor:   return ~(a | b);
      cpu_isa_pkg::op_xor:   return a ^ b;
      cpu_isa_pkg::op_sll:   return a << b[4:0];
      cpu_isa_pkg::op_srl:   return a >> b[4:0];
      cpu_isa_pkg::op_sra:   return $signed(a) >>> b[4:0];
      cpu_isa_pkg::op_lui:   return b;
      cpu_isa_pkg::op_mul:   return sp[31:0];
      cpu_isa_pkg::op_mulh:  return sp[63:32];
      cpu_isa_pkg::op_mulhu: return up[63:32];
      cpu_isa_pkg::op_div:   return (b == 0) ? 32'hffff_ffff : sq;
      cpu_isa_pkg::op_mod:   return (b == 0) ? a : sr;
      cpu_isa_pkg::op_divu:  return (b == 0) ? 32'hffff_ffff : a / b;
      cpu_isa_pkg::op_modu:  return (b == 0) ? a : a % b;
      default:               return 32'd0;
    endcase
  endfunction

  // strobe and lane data expected for a memory access
  function automatic exe_bus_pkg::sram_req_t sram_expect(input logic [2:0] st,
                                                         input logic [31:0] addr, rkd);
    exe_bus_pkg::sram_req_t r;
    r.en    = 1'b1;
    r.addr  = addr;
    r.we    = 4'b0000;
    r.wdata = rkd;
    if (st == 3'b001) begin
      case (addr[1:0])
        2'd0: r.we = 4'b0001;
        2'd1: r.we = 4'b0010;
        2'd2: r.we = 4'b0100;
        default: r.we = 4'b1000;
      endcase
      r.wdata = {rkd[7:0], rkd[7:0], rkd[7:0], rkd[7:0]};
    end else if (st == 3'b010) begin
      r.we    = addr[1] ? 4'b1100 : 4'b0011;
      r.wdata = {rkd[15:0], rkd[15:0]};
    end else if (st == 3'b100) begin
      r.we = 4'b1111;
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      $display("Error %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // put entry i on the decode bus and work out what should come back
  task automatic present(input int i, input int pass_no);
    vec_t        v;
    logic [31:0] a;
    logic [31:0] b;
    v = vectors[i];
    a = v.src1;
    b = v.src2;
    if (v.rnd) begin
      a = $random(seed);
      b = $random(seed);
    end
    ds2es_bus           = '0;
    ds2es_bus.pc        = 32'h1c00_0000 + seq * 4;
    ds2es_bus.src1      = a;
    ds2es_bus.src2      = b;
    ds2es_bus.alu_op[v.op] = 1'b1;
    ds2es_bus.load_op   = v.ld;
    ds2es_bus.store_op  = v.st;
    ds2es_bus.rkd_value = v.rkd;
    ds2es_bus.gr_we     = (v.st == 3'b000);
    ds2es_bus.dest      = v.dest;
    ds2es_valid         = 1'b1;
    cur_exp.idx     = i;
    cur_exp.pass_no = pass_no;
    cur_exp.pc      = ds2es_bus.pc;
    cur_exp.result  = v.rnd ? model_alu(v.op, a, b) : v.exp;
    cur_exp.ld      = v.ld;
    cur_exp.dest    = v.dest;
    cur_exp.gr_we   = ds2es_bus.gr_we;
    cur_is_mem      = (v.st != 3'b000) || (v.ld != 5'b00000);
    cur_mem.req      = sram_expect(v.st, cur_exp.result, v.rkd);
    cur_mem.is_store = (v.st != 3'b000);
    seq++;
  endtask

  task automatic run_pass(input int pass_no, input bit random_bp);
    bit          accepted;
    logic [31:0] rnd_word;
    for (int i = 0; i < n_vec; i++) begin
      present(i, pass_no);
      do begin
        @(posedge clk);
        accepted = es_allowin;
        if (accepted) begin
          res_q.push_back(cur_exp);
          if (cur_is_mem) mem_q.push_back(cur_mem);
        end
        @(negedge clk);
        rnd_word   = $random(seed);
        ms_allowin = random_bp ? rnd_word[0] : 1'b1;
      end while (!accepted);
    end
    ds2es_valid = 1'b0;
    ms_allowin  = 1'b1;
    while (res_q.size() != 0 || mem_q.size() != 0) @(negedge clk);
  endtask

  always @(posedge clk) begin : monitor
    exp_t      e;
    mem_item_t m;
    int        err0;
    if (!reset && es2ms_valid && ms_allowin) begin
      err0 = errors;
      results_seen++;
      assert (res_q.size() != 0) else begin
        $display("Result at %0t arrived with no instruction outstanding", $time);
        errors++;
      end
      if (res_q.size() != 0) begin
        e = res_q.pop_front();
        if (e.pass_no == 0) xfer_cyc[e.idx] = cycles;
        check_value("alu_result", es2ms_bus.alu_result, e.result);
        check_value("pc", es2ms_bus.pc, e.pc);
        check_value("dest", 32'(es2ms_bus.dest), 32'(e.dest));
        check_value("gr_we", 32'(es2ms_bus.gr_we), 32'(e.gr_we));
        check_value("load_op", 32'(es2ms_bus.load_op), 32'(e.ld));
        $display("test %0d.%0d op %0d %s", e.pass_no, e.idx, vectors[e.idx].op,
                 (errors == err0) ? "ok" : "FAILED");
      end
    end
    if (!reset && data_sram.en) begin
      assert (mem_q.size() != 0) else begin
        $display("data_sram.en raised at %0t with no load or store pending", $time);
        errors++;
      end
      if (mem_q.size() != 0) begin
        m = mem_q.pop_front();
        check_value("sram we", 32'(data_sram.we), 32'(m.req.we));
        check_value("sram addr", data_sram.addr, m.req.addr);
        if (m.is_store) check_value("sram wdata", data_sram.wdata, m.req.wdata);
      end
    end
    cycles++;
  end

  always @(posedge clk) begin
    if (cycles > timeout_limit) begin
      $display("Timeout: run passed %0d cycles without finishing", timeout_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int err0;
    seed         = 32'h8dfc69de;
    errors       = 0;
    checks       = 0;
    results_seen = 0;
    cycles       = 0;
    seq          = 0;
    reset        = 1'b1;
    ds2es_valid  = 1'b0;
    ds2es_bus    = '0;
    ms_allowin   = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    err0 = errors;
    check_value("es2ms_valid after reset", 32'(es2ms_valid), 32'd0);
    check_value("data_sram.en after reset", 32'(data_sram.en), 32'd0);
    check_value("es_allowin after reset", 32'(es_allowin), 32'd1);
    $display("test reset state %s", (errors == err0) ? "ok" : "FAILED");

    run_pass(0, 1'b0);  // ms_allowin held high
    err0 = errors;
    for (int i = 1; i < n_vec; i++) begin
      if (vectors[i].op < cpu_isa_pkg::op_mul)
        check_value($sformatf("transfer cycle of entry %0d", i), xfer_cyc[i], xfer_cyc[i-1] + 1);
    end
    $display("test back-to-back %s", (errors == err0) ? "ok" : "FAILED");

    run_pass(1, 1'b1);  // random back-pressure
    repeat (4) @(negedge clk);  // idle, nothing more may come out
    err0 = errors;
    check_value("result count", results_seen, 2 * n_vec);
    $display("test result count %s", (errors == err0) ? "ok" : "FAILED");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
